/* run.sh */
#!/bin/bash
# Builds the FPU slice testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
  --top-module fpuTb -f vlog.f -Mdir "$OBJ" -o fpuSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/fpuSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi

if ! grep -q "SIMULATION PASSED" "$LOG"; then
  echo "No pass line found in the log"
  exit 1
fi

exit 0

/* source/fpDecoder.sv */
// FP decoder, decodes the D instruction, flags illegal encodings and pipes control to E/M/W
`timescale 1ns/100ps

module fpDecoder (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              stall,          // Freezes E/M/W
  input  logic                              bubbleE,        // Load-use bubble into E
  input  logic [31:0]                       instrD,
  input  logic [1:0]                        statusFs,       // mstatus.FS, 0 = off
  output logic                              illegalInstrD,
  output fpuPkg::fpOpT                      opD, opE, opM, opW,
  output logic [fpuPkg::RegAddrWidth-1:0]   rs1D, rs2D, rs3D,
  output logic [fpuPkg::RegAddrWidth-1:0]   rdE, rdM, rdW,
  output logic                              regWriteE, regWriteM, regWriteW,
  output logic                              readsRs1D, readsRs2D,
  output logic                              intWriteM       // Result goes to the integer file
);

  fpuPkg::fpOpT                    opDec;     // Raw decode before the FS check
  logic                            regWriteD;
  logic [6:0]                      opcode, funct7;
  logic [2:0]                      funct3;
  logic [fpuPkg::RegAddrWidth-1:0] rdD;

  assign opcode = instrD[6:0];
  assign funct3 = instrD[14:12];
  assign funct7 = instrD[31:25];
  assign rdD    = instrD[11:7];
  assign rs1D   = instrD[19:15];
  assign rs2D   = instrD[24:20];
  assign rs3D   = instrD[31:27];  // R4 field, no fused ops here

  //////////////////////////////////////////////////////////////////////
  // Decode

  always_comb begin
    opDec = fpuPkg::OpNone;  // Anything not matched is illegal
    if (opcode == fpuPkg::OpcodeLoadFp && funct3 == 3'b010)
      opDec = fpuPkg::OpLoad;
    else if (opcode == fpuPkg::OpcodeStoreFp && funct3 == 3'b010)
      opDec = fpuPkg::OpStore;
    else if (opcode == fpuPkg::OpcodeOpFp) begin
      case (funct7)
        fpuPkg::Funct7Sgnj:
          case (funct3)
            3'b000:  opDec = fpuPkg::OpSgnj;
            3'b001:  opDec = fpuPkg::OpSgnjn;
            3'b010:  opDec = fpuPkg::OpSgnjx;
            default: opDec = fpuPkg::OpNone;
          endcase
        fpuPkg::Funct7MinMax:
          case (funct3)
            3'b000:  opDec = fpuPkg::OpMin;
            3'b001:  opDec = fpuPkg::OpMax;
            default: opDec = fpuPkg::OpNone;
          endcase
        fpuPkg::Funct7Cmp:
          case (funct3)
            3'b010:  opDec = fpuPkg::OpEq;
            3'b001:  opDec = fpuPkg::OpLt;
            3'b000:  opDec = fpuPkg::OpLe;
            default: opDec = fpuPkg::OpNone;
          endcase
        fpuPkg::Funct7ClassMv:                       // rs2 must be zero
          if (rs2D == '0 && funct3 == 3'b000)
            opDec = fpuPkg::OpMvXW;
          else if (rs2D == '0 && funct3 == 3'b001)
            opDec = fpuPkg::OpClass;
        fpuPkg::Funct7MvWX:
          if (rs2D == '0 && funct3 == 3'b000)
            opDec = fpuPkg::OpMvWX;
        default: opDec = fpuPkg::OpNone;             // fadd, fmul, fcvt etc
      endcase
    end
  end

  assign illegalInstrD = (opDec == fpuPkg::OpNone) | (statusFs == 2'b00);
  assign opD = illegalInstrD ? fpuPkg::OpNone : opDec;  // Illegal ones travel as bubbles

  // Which ops write an FP register and which FP sources they read
  assign regWriteD = opD inside {fpuPkg::OpLoad, fpuPkg::OpSgnj, fpuPkg::OpSgnjn,
                                 fpuPkg::OpSgnjx, fpuPkg::OpMin, fpuPkg::OpMax,
                                 fpuPkg::OpMvWX};
  assign readsRs1D = opD inside {fpuPkg::OpSgnj, fpuPkg::OpSgnjn, fpuPkg::OpSgnjx,
                                 fpuPkg::OpMin, fpuPkg::OpMax, fpuPkg::OpEq, fpuPkg::OpLt,
                                 fpuPkg::OpLe, fpuPkg::OpClass, fpuPkg::OpMvXW};
  assign readsRs2D = opD inside {fpuPkg::OpStore, fpuPkg::OpSgnj, fpuPkg::OpSgnjn,
                                 fpuPkg::OpSgnjx, fpuPkg::OpMin, fpuPkg::OpMax,
                                 fpuPkg::OpEq, fpuPkg::OpLt, fpuPkg::OpLe};

  //////////////////////////////////////////////////////////////////////
  // E/M/W control pipeline

  always_ff @(posedge clk) begin
    if (reset) begin
      opE       <= fpuPkg::OpNone;
      opM       <= fpuPkg::OpNone;
      opW       <= fpuPkg::OpNone;
      regWriteE <= 1'b0;
      regWriteM <= 1'b0;
      regWriteW <= 1'b0;
    end else if (!stall) begin
      opE       <= bubbleE ? fpuPkg::OpNone : opD;
      regWriteE <= regWriteD & ~bubbleE;
      opM       <= opE;
      regWriteM <= regWriteE;
      opW       <= opM;
      regWriteW <= regWriteM;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      rdE <= rdD;
      rdM <= rdE;
      rdW <= rdM;
    end
  end

  assign intWriteM = opM inside {fpuPkg::OpEq, fpuPkg::OpLt, fpuPkg::OpLe,
                                 fpuPkg::OpClass, fpuPkg::OpMvXW};

  // An illegal instruction must never reach the execute stage as a live op
  assert property (@(posedge clk) disable iff (reset)
                   illegalInstrD && !stall |=> opE == fpuPkg::OpNone)
    else $error("illegal instruction reached E as a live op");

endmodule

/* source/fpHazard.sv */
// FP hazard unit, picks E operand forwarding from M or W and raises the load-use stall
`timescale 1ns/100ps

module fpHazard (
  input  logic [fpuPkg::RegAddrWidth-1:0]   rs1D, rs2D,
  input  logic                              readsRs1D, readsRs2D,
  input  fpuPkg::fpOpT                      opE,
  input  logic [fpuPkg::RegAddrWidth-1:0]   rdE,
  input  logic                              regWriteE,
  input  logic [fpuPkg::RegAddrWidth-1:0]   rs1E, rs2E,
  input  logic [fpuPkg::RegAddrWidth-1:0]   rdM,
  input  logic                              regWriteM,
  input  fpuPkg::fpOpT                      opM,
  input  logic [fpuPkg::RegAddrWidth-1:0]   rdW,
  input  logic                              regWriteW,
  output logic [1:0]                        forwardXE,  // 00 regfile, 01 W, 10 M
  output logic [1:0]                        forwardYE,
  output logic                              fpuStallD
);

  logic loadInE;

  // M wins over W, a load in M has no data yet
  function automatic logic [1:0] fwdSel(input logic [fpuPkg::RegAddrWidth-1:0] rs);
    if (regWriteM && opM != fpuPkg::OpLoad && rdM == rs)
      return 2'b10;
    else if (regWriteW && rdW == rs)
      return 2'b01;
    else
      return 2'b00;
  endfunction

  assign forwardXE = fwdSel(rs1E);
  assign forwardYE = fwdSel(rs2E);

  // flw in E feeding the D instruction, one bubble lets it reach W
  assign loadInE   = regWriteE & (opE == fpuPkg::OpLoad);
  assign fpuStallD = loadInE & ((readsRs1D & (rs1D == rdE)) | (readsRs2D & (rs2D == rdE)));

endmodule

/* source/fpRegFile.sv */
// FP register file, two reads in D and one write from W, with write-through to the read ports
`timescale 1ns/100ps

module fpRegFile (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              writeEn,
  input  logic [fpuPkg::RegAddrWidth-1:0]   writeAddr,
  input  logic [fpuPkg::FpWidth-1:0]        writeData,
  input  logic [fpuPkg::RegAddrWidth-1:0]   readAddr1,
  input  logic [fpuPkg::RegAddrWidth-1:0]   readAddr2,   // Also the fsw data source
  output logic [fpuPkg::FpWidth-1:0]        readData1,
  output logic [fpuPkg::FpWidth-1:0]        readData2
);

  logic [fpuPkg::FpWidth-1:0] regs [1 << fpuPkg::RegAddrWidth];  // f0 is an ordinary register

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < (1 << fpuPkg::RegAddrWidth); i++)
        regs[i] <= '0;
    end else if (writeEn) begin
      regs[writeAddr] <= writeData;
    end
  end

  // Write-through, so a D read sees the W write of the same cycle
  assign readData1 = (writeEn && writeAddr == readAddr1) ? writeData : regs[readAddr1];
  assign readData2 = (writeEn && writeAddr == readAddr2) ? writeData : regs[readAddr2];

endmodule

/* source/fpSimpleOps.sv */
// Single-cycle FP ops in E, sign injection, min/max, compares, fclass and fmv.x.w
`timescale 1ns/100ps

module fpSimpleOps (
  input  fpuPkg::fpOpT                  opE,
  input  logic [fpuPkg::FpWidth-1:0]    xE, yE,
  input  logic                          xSign, ySign,
  input  logic [fpuPkg::ExpWidth-1:0]   xExp, yExp,
  input  logic [fpuPkg::FracWidth-1:0]  xFrac, yFrac,
  input  logic                          xZero, yZero,
  input  logic                          xSubnorm,
  input  logic                          xInf,
  input  logic                          xNan, yNan,
  input  logic                          xSnan, ySnan,
  output logic [fpuPkg::FpWidth-1:0]    fpResE,    // To the FP register path
  output logic [fpuPkg::FpWidth-1:0]    intResE,   // To the integer register path
  output logic                          invalidE   // NV flag
);

  localparam logic [fpuPkg::FpWidth-1:0] CanonNan = 32'h7FC00000;

  logic                              magLt, magEq;      // |x| vs |y|
  logic                              ltOrd;             // x < y with -0 < +0
  logic                              bothZero, anyNan;
  logic                              eqRes, ltRes, leRes;
  logic                              sgnBit, xNormal;
  logic [fpuPkg::FpWidth-1:0]        sgnRes, minMaxRes;
  logic [fpuPkg::ClassWidth-1:0]     classRes;

  //////////////////////////////////////////////////////////////////////
  // Compare core

  assign magLt    = {xExp, xFrac} < {yExp, yFrac};
  assign magEq    = {xExp, xFrac} == {yExp, yFrac};
  assign bothZero = xZero & yZero;
  assign anyNan   = xNan | yNan;

  // Differing signs, negative one is smaller; both negative, larger magnitude is smaller
  assign ltOrd = (xSign ^ ySign) ? xSign : (xSign ? ~(magLt | magEq) : magLt);

  assign eqRes = ~anyNan & ((magEq & (xSign == ySign)) | bothZero);  // +0 == -0
  assign ltRes = ~anyNan & ltOrd & ~bothZero;
  assign leRes = ltRes | eqRes;

  // minimumNumber/maximumNumber, a single NaN loses
  always_comb begin
    if (xNan && yNan)
      minMaxRes = CanonNan;
    else if (xNan)
      minMaxRes = yE;
    else if (yNan)
      minMaxRes = xE;
    else if (opE == fpuPkg::OpMin)
      minMaxRes = ltOrd ? xE : yE;
    else
      minMaxRes = ltOrd ? yE : xE;
  end

  //////////////////////////////////////////////////////////////////////
  // Sign injection and classify

  always_comb begin
    case (opE)
      fpuPkg::OpSgnjn: sgnBit = ~ySign;
      fpuPkg::OpSgnjx: sgnBit = xSign ^ ySign;
      default:         sgnBit = ySign;            // fsgnj
    endcase
  end
  assign sgnRes = {sgnBit, xE[fpuPkg::FpWidth-2:0]};  // Magnitude from X

  assign xNormal  = ~(xZero | xSubnorm | xInf | xNan);
  assign classRes = {xNan & ~xSnan, xSnan,                       // qNaN, sNaN
                     ~xSign & xInf, ~xSign & xNormal, ~xSign & xSubnorm, ~xSign & xZero,
                     xSign & xZero, xSign & xSubnorm, xSign & xNormal, xSign & xInf};

  //////////////////////////////////////////////////////////////////////
  // Result select

  always_comb begin
    fpResE   = sgnRes;
    intResE  = '0;
    invalidE = 1'b0;
    case (opE)
      fpuPkg::OpMin, fpuPkg::OpMax: begin
        fpResE   = minMaxRes;
        invalidE = xSnan | ySnan;
      end
      fpuPkg::OpEq: begin
        intResE  = {{(fpuPkg::FpWidth-1){1'b0}}, eqRes};
        invalidE = xSnan | ySnan;                 // Quiet compare
      end
      fpuPkg::OpLt: begin
        intResE  = {{(fpuPkg::FpWidth-1){1'b0}}, ltRes};
        invalidE = anyNan;                        // Signaling compares
      end
      fpuPkg::OpLe: begin
        intResE  = {{(fpuPkg::FpWidth-1){1'b0}}, leRes};
        invalidE = anyNan;
      end
      fpuPkg::OpClass: intResE = {{(fpuPkg::FpWidth-fpuPkg::ClassWidth){1'b0}}, classRes};
      fpuPkg::OpMvXW:  intResE = xE;              // Raw bit move
      default: ;
    endcase
  end

  always_comb begin
    if (opE == fpuPkg::OpClass)
      assert ($onehot(intResE)) else $error("fclass result is not one-hot");
  end

endmodule

/* source/fpUnpack.sv */
// Operand unpacker, splits both E operands into fields and classifies each one
`timescale 1ns/100ps

module fpUnpack (
  input  logic [fpuPkg::FpWidth-1:0]    xE, yE,
  output logic                          xSign, ySign,
  output logic [fpuPkg::ExpWidth-1:0]   xExp, yExp,
  output logic [fpuPkg::FracWidth-1:0]  xFrac, yFrac,
  output logic                          xZero, yZero,
  output logic                          xSubnorm, ySubnorm,
  output logic                          xInf, yInf,
  output logic                          xNan, yNan,
  output logic                          xSnan, ySnan
);

  // {zero, subnorm, inf, nan, snan} from exponent and fraction
  function automatic logic [4:0] classify(input logic [fpuPkg::ExpWidth-1:0] e,
                                          input logic [fpuPkg::FracWidth-1:0] f);
    logic expZero, expMax, fracZero;
    expZero  = ~|e;
    expMax   = &e;
    fracZero = ~|f;
    return {expZero & fracZero, expZero & ~fracZero, expMax & fracZero,
            expMax & ~fracZero, expMax & ~fracZero & ~f[fpuPkg::FracWidth-1]};  // Quiet bit clear
  endfunction

  assign {xSign, xExp, xFrac} = xE;
  assign {ySign, yExp, yFrac} = yE;

  assign {xZero, xSubnorm, xInf, xNan, xSnan} = classify(xExp, xFrac);
  assign {yZero, ySubnorm, yInf, yNan, ySnan} = classify(yExp, yFrac);

  // Classes must be exclusive, fclass and min/max rely on it
  always_comb begin
    assert ($onehot0({xZero, xSubnorm, xInf, xNan}) && $onehot0({yZero, ySubnorm, yInf, yNan}))
      else $error("operand falls in more than one class");
  end

endmodule

/* source/fpu.sv */
// FPU slice top level, D/E/M/W pipeline registers, forwarding and writeback select
`timescale 1ns/100ps

module fpu (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          stall,          // Freezes the whole pipe
  input  logic [1:0]                    statusFs,
  input  logic [31:0]                   instrD,
  input  logic [fpuPkg::FpWidth-1:0]    srcAE,          // fmv.w.x source from the IEU
  input  logic [fpuPkg::FpWidth-1:0]    readDataW,      // flw data from the LSU
  output logic                          illegalInstrD,
  output logic                          fpuStallD,
  output logic                          fpLoadStoreM,
  output logic [fpuPkg::FpWidth-1:0]    fWriteDataM,    // fsw data
  output logic                          intWriteM,
  output logic [fpuPkg::FpWidth-1:0]    intResM,
  output logic [4:0]                    setFlagsM
);

  fpuPkg::fpOpT                      opE, opM, opW;
  logic [fpuPkg::RegAddrWidth-1:0]   rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;
  logic                              regWriteE, regWriteM, regWriteW;
  logic                              readsRs1D, readsRs2D;
  logic [1:0]                        forwardXE, forwardYE;
  logic [fpuPkg::FpWidth-1:0]        rd1D, rd2D, rd1E, rd2E;   // Regfile data
  logic [fpuPkg::FpWidth-1:0]        xE, yE;                   // Forwarded operands
  logic                              xSign, ySign, xZero, yZero, xSubnorm, xInf;
  logic                              xNan, yNan, xSnan, ySnan;
  logic [fpuPkg::ExpWidth-1:0]       xExp, yExp;
  logic [fpuPkg::FracWidth-1:0]      xFrac, yFrac;
  logic [fpuPkg::FpWidth-1:0]        fpResE, intResE, preFpResE;
  logic                              invalidE, invalidM;
  logic [fpuPkg::FpWidth-1:0]        fpResM, fpResW, resultW;

  //////////////////////////////////////////////////////////////////////
  // Decode stage

  fpDecoder decoder (.clk, .reset, .stall, .bubbleE(fpuStallD), .instrD, .statusFs,
    .illegalInstrD, .opD(), .opE, .opM, .opW, .rs1D, .rs2D, .rs3D(),
    .rdE, .rdM, .rdW, .regWriteE, .regWriteM, .regWriteW,
    .readsRs1D, .readsRs2D, .intWriteM);

  fpRegFile regFile (.clk, .reset, .writeEn(regWriteW & ~stall), .writeAddr(rdW),
    .writeData(resultW), .readAddr1(rs1D), .readAddr2(rs2D),
    .readData1(rd1D), .readData2(rd2D));

  // D/E operands, a bubble makes them don't-care
  always_ff @(posedge clk) begin
    if (!stall) begin
      rd1E <= rd1D;
      rd2E <= rd2D;
      rs1E <= rs1D;
      rs2E <= rs2D;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Execute stage

  fpHazard hazard (.rs1D, .rs2D, .readsRs1D, .readsRs2D, .opE, .rdE, .regWriteE,
    .rs1E, .rs2E, .rdM, .regWriteM, .opM, .rdW, .regWriteW,
    .forwardXE, .forwardYE, .fpuStallD);

  // Forwarding muxes, M then W then regfile
  assign xE = forwardXE[1] ? fpResM : (forwardXE[0] ? resultW : rd1E);
  assign yE = forwardYE[1] ? fpResM : (forwardYE[0] ? resultW : rd2E);

  fpUnpack unpack (.xE, .yE, .xSign, .ySign, .xExp, .yExp, .xFrac, .yFrac,
    .xZero, .yZero, .xSubnorm, .ySubnorm(), .xInf, .yInf(),
    .xNan, .yNan, .xSnan, .ySnan);

  fpSimpleOps simpleOps (.opE, .xE, .yE, .xSign, .ySign, .xExp, .yExp, .xFrac, .yFrac,
    .xZero, .yZero, .xSubnorm, .xInf, .xNan, .yNan, .xSnan, .ySnan,
    .fpResE, .intResE, .invalidE);

  assign preFpResE = (opE == fpuPkg::OpMvWX) ? srcAE : fpResE;  // fmv.w.x joins here

  // E/M registers
  always_ff @(posedge clk) begin
    if (reset)
      invalidM <= 1'b0;
    else if (!stall)
      invalidM <= invalidE;
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      fpResM      <= preFpResE;
      intResM     <= intResE;
      fWriteDataM <= yE;                          // Store data after forwarding
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Memory stage

  assign fpLoadStoreM = (opM == fpuPkg::OpLoad) | (opM == fpuPkg::OpStore);

  always_comb begin
    setFlagsM                 = '0;
    setFlagsM[fpuPkg::FlagNv] = invalidM;         // Only NV can be raised here
  end

  always_ff @(posedge clk) begin
    if (!stall)
      fpResW <= fpResM;
  end

  //////////////////////////////////////////////////////////////////////
  // Writeback stage

  assign resultW = (opW == fpuPkg::OpLoad) ? readDataW : fpResW;

  // Load-use bubble lasts one cycle unless the core holds the pipe
  assert property (@(posedge clk) disable iff (reset) fpuStallD && !stall |=> !fpuStallD)
    else $error("fpuStallD high past its single bubble");

endmodule

/* source/fpuPkg.sv */
// Common widths, RISC-V single-precision encodings and the per-stage operation type
package fpuPkg;

  // Word and field widths, single precision only
  parameter int FpWidth      = 32;  // FP register data and integer results
  parameter int ExpWidth     = 8;
  parameter int FracWidth    = 23;
  parameter int RegAddrWidth = 5;   // 32 FP registers
  parameter int ClassWidth   = 10;  // fclass one-hot field

  //////////////////////////////////////////////////////////////////////
  // Major opcodes
  parameter logic [6:0] OpcodeLoadFp  = 7'b0000111;  // flw
  parameter logic [6:0] OpcodeStoreFp = 7'b0100111;  // fsw
  parameter logic [6:0] OpcodeOpFp    = 7'b1010011;

  // funct7 of the supported OP-FP groups, fmt bits = S
  parameter logic [6:0] Funct7Sgnj    = 7'b0010000;
  parameter logic [6:0] Funct7MinMax  = 7'b0010100;
  parameter logic [6:0] Funct7Cmp     = 7'b1010000;
  parameter logic [6:0] Funct7ClassMv = 7'b1110000;  // fclass and fmv.x.w
  parameter logic [6:0] Funct7MvWX    = 7'b1111000;

  //////////////////////////////////////////////////////////////////////
  // Operation carried down the pipe, OpNone is a bubble or an illegal instruction
  typedef enum logic [3:0] {
    OpNone, OpLoad, OpStore,
    OpSgnj, OpSgnjn, OpSgnjx,
    OpMin, OpMax,
    OpEq, OpLt, OpLe,
    OpClass, OpMvXW, OpMvWX
  } fpOpT;

  // Position of NV in the NV/DZ/OF/UF/NX flag field
  parameter int FlagNv = 4;

endpackage

/* tests/fpuTb.sv */
// Self-checking testbench for the FPU slice, drives instructions and checks M-stage outputs
`timescale 1ns/100ps

module fpuTb;

  localparam int NumInstr = 114;                 // Instructions issued by the stimulus
  localparam int Limit    = NumInstr * 4 + 50;   // Timeout in cycles

  logic        clk, reset, stall;
  logic [1:0]  statusFs;
  logic [31:0] instrD, srcAE, readDataW;
  logic        illegalInstrD, fpuStallD, fpLoadStoreM, intWriteM;
  logic [31:0] fWriteDataM, intResM;
  logic [4:0]  setFlagsM;

  logic [31:0] model [32];                       // Architectural FP registers
  logic [67:0] expQ [$];                         // Expected M values in program order
  logic [67:0] dEnt, mEnt;
  logic        dValid, eV, mV;
  logic [31:0] dLd, eLd, mLd, wLd, pendingSrc;
  logic        mStore, mLs, mIntW, mNv;
  logic [31:0] mIntRes, mStData;
  logic [31:0] seed, pairA [8], pairB [8], classVal [10];
  int          errors, cycles, lastStalls;
  string       testName;

  fpu i_dut (.clk, .reset, .stall, .statusFs, .instrD, .srcAE, .readDataW,
    .illegalInstrD, .fpuStallD, .fpLoadStoreM, .fWriteDataM, .intWriteM, .intResM,
    .setFlagsM);

  always #10 clk = ~clk;                         // 20 ns period

  //////////////////////////////////////////////////////////////////////
  // Shadow pipeline, follows each accepted instruction to M and W

  always @(posedge clk) begin
    if (reset) begin
      eV   <= 1'b0;
      mV   <= 1'b0;
      mEnt <= '0;
      eLd  <= '0;
      mLd  <= '0;
      wLd  <= '0;
    end else begin
      mV <= eV;
      if (eV) mEnt <= expQ.pop_front();          // Oldest entry reaches M
      if (dValid && !fpuStallD) expQ.push_back(dEnt);
      eV  <= dValid && !fpuStallD;               // Load-use bubble is not pushed
      eLd <= dLd;
      mLd <= eLd;
      wLd <= mLd;
    end
  end

  always @(negedge clk) readDataW <= wLd;        // Load data while the flw is in W

  assign {mStore, mLs, mIntW, mNv, mIntRes, mStData} = mEnt;

  //////////////////////////////////////////////////////////////////////
  // M-stage checks

  assert property (@(posedge clk) disable iff (reset) intWriteM == (mV && mIntW))
    else begin
      errors++;
      $display("Error %s: intWriteM expected %b, actual %b", testName,
               $sampled(mV && mIntW), $sampled(intWriteM));
    end
  assert property (@(posedge clk) disable iff (reset) mV && mIntW |-> intResM == mIntRes)
    else begin
      errors++;
      $display("Error %s: intResM expected %h, actual %h", testName,
               $sampled(mIntRes), $sampled(intResM));
    end
  assert property (@(posedge clk) disable iff (reset) mV |-> setFlagsM == {mNv, 4'b0})
    else begin
      errors++;
      $display("Error %s: setFlagsM expected %b, actual %b", testName,
               $sampled({mNv, 4'b0}), $sampled(setFlagsM));
    end
  assert property (@(posedge clk) disable iff (reset) fpLoadStoreM == (mV && mLs))
    else begin
      errors++;
      $display("Error %s: fpLoadStoreM expected %b, actual %b", testName,
               $sampled(mV && mLs), $sampled(fpLoadStoreM));
    end
  assert property (@(posedge clk) disable iff (reset) mV && mStore |-> fWriteDataM == mStData)
    else begin
      errors++;
      $display("Error %s: fWriteDataM expected %h, actual %h", testName,
               $sampled(mStData), $sampled(fWriteDataM));
    end

  //////////////////////////////////////////////////////////////////////
  // Reference rules

  function automatic logic isNan(input logic [31:0] v);
    return (v[30:23] == 8'hFF) && (v[22:0] != 0);
  endfunction

  function automatic logic isSnan(input logic [31:0] v);
    return isNan(v) && !v[22];
  endfunction

  // Ordered a < b on non-NaN values, -0 below +0
  function automatic logic ordLess(input logic [31:0] a, input logic [31:0] b);
    if (a[31] != b[31]) return a[31];
    return a[31] ? (a[30:0] > b[30:0]) : (a[30:0] < b[30:0]);
  endfunction

  function automatic logic [31:0] classOf(input logic [31:0] v);
    int idx;
    if (isSnan(v)) idx = 8;
    else if (isNan(v)) idx = 9;
    else if (v[30:23] == 8'hFF) idx = v[31] ? 0 : 7;
    else if (v[30:23] == 0) idx = (v[22:0] == 0) ? (v[31] ? 3 : 4) : (v[31] ? 2 : 5);
    else idx = v[31] ? 1 : 6;
    return 32'd1 << idx;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Issue helpers

  // Holds one instruction in D until the DUT takes it
  task automatic send(input logic [31:0] instr, input logic [31:0] src, input logic ill,
                      input logic [67:0] ent);
    @(negedge clk);
    srcAE      = pendingSrc;                     // For the instruction now in E
    instrD     = instr;
    dValid     = 1'b1;
    dEnt       = ent;
    dLd        = src;
    pendingSrc = src;
    #1;
    assert (illegalInstrD == ill) else begin
      errors++;
      $display("Error %s: illegalInstrD expected %b, actual %b", testName, ill, illegalInstrD);
    end
    lastStalls = 0;
    while (fpuStallD) begin
      lastStalls++;
      @(negedge clk);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      srcAE  = pendingSrc;
      instrD = 32'h00000013;                     // Integer nop, not FP
      dValid = 1'b0;
    end
  endtask

  task automatic exec(input fpuPkg::fpOpT op, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [4:0] rs2, input logic [31:0] data);
    logic [31:0] a, b, fpRes, intRes, instr;
    logic        nv, intW, fpW, ls, st;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [67:0] ent;
    a = model[rs1];
    b = model[rs2];
    fpRes = 0;
    intRes = 0;
    nv = 0;
    intW = 0;
    fpW = 1;
    ls = 0;
    st = 0;
    f3 = 0;
    f7 = 7'b0010000;
    case (op)
      fpuPkg::OpLoad: begin
        fpRes = data;
        ls    = 1;
      end
      fpuPkg::OpStore: begin
        fpW = 0;
        ls  = 1;
        st  = 1;
      end
      fpuPkg::OpSgnj:   fpRes = {b[31], a[30:0]};
      fpuPkg::OpSgnjn: begin
        f3    = 1;
        fpRes = {~b[31], a[30:0]};
      end
      fpuPkg::OpSgnjx: begin
        f3    = 2;
        fpRes = {a[31] ^ b[31], a[30:0]};
      end
      fpuPkg::OpMin, fpuPkg::OpMax: begin
        f7 = 7'b0010100;
        f3 = (op == fpuPkg::OpMax);
        nv = isSnan(a) || isSnan(b);
        if (isNan(a) && isNan(b)) fpRes = 32'h7FC00000;
        else if (isNan(a)) fpRes = b;
        else if (isNan(b)) fpRes = a;
        else fpRes = (ordLess(a, b) ^ (op == fpuPkg::OpMax)) ? a : b;
      end
      fpuPkg::OpEq, fpuPkg::OpLt, fpuPkg::OpLe: begin
        f7 = 7'b1010000;
        fpW = 0;
        intW = 1;
        f3 = (op == fpuPkg::OpEq) ? 3'd2 : (op == fpuPkg::OpLt) ? 3'd1 : 3'd0;
        nv = (op == fpuPkg::OpEq) ? (isSnan(a) || isSnan(b)) : (isNan(a) || isNan(b));
        if (!isNan(a) && !isNan(b)) begin
          intRes[0] = (a == b) || (a[30:0] == 0 && b[30:0] == 0);      // +0 == -0
          if (op == fpuPkg::OpLt) intRes[0] = !intRes[0] && ordLess(a, b);
          if (op == fpuPkg::OpLe) intRes[0] = intRes[0] || ordLess(a, b);
        end
      end
      fpuPkg::OpClass: begin
        f7     = 7'b1110000;
        f3     = 1;
        fpW    = 0;
        intW   = 1;
        intRes = classOf(a);
      end
      fpuPkg::OpMvXW: begin
        f7     = 7'b1110000;
        fpW    = 0;
        intW   = 1;
        intRes = a;
      end
      fpuPkg::OpMvWX: begin
        f7    = 7'b1111000;
        fpRes = data;
      end
      default: ;
    endcase
    if (op == fpuPkg::OpLoad)
      instr = {12'h010, rs1, 3'b010, rd, 7'b0000111};
    else if (op == fpuPkg::OpStore)
      instr = {7'h0, rs2, rs1, 3'b010, 5'h4, 7'b0100111};
    else if (op inside {fpuPkg::OpClass, fpuPkg::OpMvXW, fpuPkg::OpMvWX})
      instr = {f7, 5'd0, rs1, f3, rd, 7'b1010011};
    else
      instr = {f7, rs2, rs1, f3, rd, 7'b1010011};
    if (fpW) model[rd] = fpRes;
    ent = {st, ls, intW, nv, intRes, b};         // Store data comes from rs2
    send(instr, data, 1'b0, ent);
  endtask

  task automatic illegal(input logic [31:0] instr);
    send(instr, 32'h0, 1'b1, '0);                // Travels as a bubble
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    clk        = 0;
    reset      = 1;
    stall      = 0;
    statusFs   = 2'b01;
    instrD     = 32'h13;
    srcAE      = 0;
    readDataW  = 0;
    dValid     = 0;
    dEnt       = 0;
    dLd        = 0;
    pendingSrc = 0;
    errors     = 0;
    cycles     = 0;
    testName   = "reset";
    seed       = 32'h2e673a20;
    for (int i = 0; i < 32; i++) model[i] = 0;
    repeat (3) @(posedge clk);
    @(negedge clk) reset = 0;

    testName = "loadStore";
    for (int r = 1; r <= 4; r++) exec(fpuPkg::OpLoad, r, 2, 0, $random(seed));
    idle(4);
    for (int r = 1; r <= 4; r++) exec(fpuPkg::OpStore, 0, 2, r, 0);

    testName = "signInject";
    exec(fpuPkg::OpMvWX, 5, 1, 0, $random(seed));
    exec(fpuPkg::OpMvWX, 6, 1, 0, $random(seed));
    exec(fpuPkg::OpSgnj, 7, 5, 6, 0);
    exec(fpuPkg::OpMvXW, 0, 7, 0, 0);
    exec(fpuPkg::OpSgnjn, 7, 5, 6, 0);
    exec(fpuPkg::OpMvXW, 0, 7, 0, 0);
    exec(fpuPkg::OpSgnjx, 7, 6, 5, 0);
    exec(fpuPkg::OpMvXW, 0, 7, 0, 0);

    testName = "minMaxCompare";
    pairA = '{32'h7FC00001, 32'h7F800001, 32'h00000000, 32'h80000000,
              32'h7FC00000, 32'h7F800001, $random(seed), $random(seed) | 32'h80000000};
    pairB = '{32'h3F800000, $random(seed), 32'h80000000, 32'h00000000,
              32'h7FC00000, 32'hFF800005, $random(seed), $random(seed)};
    for (int i = 0; i < 8; i++) begin
      exec(fpuPkg::OpMvWX, 8, 1, 0, pairA[i]);
      exec(fpuPkg::OpMvWX, 9, 1, 0, pairB[i]);
      exec(fpuPkg::OpMin, 10, 8, 9, 0);
      exec(fpuPkg::OpMvXW, 0, 10, 0, 0);
      exec(fpuPkg::OpMax, 11, 8, 9, 0);
      exec(fpuPkg::OpMvXW, 0, 11, 0, 0);
      exec(fpuPkg::OpEq, 1, 8, 9, 0);
      exec(fpuPkg::OpLt, 1, 8, 9, 0);
      exec(fpuPkg::OpLe, 1, 9, 8, 0);
    end

    testName = "classify";
    classVal = '{32'hFF800000, 32'hBF800000, 32'h80000001, 32'h80000000, 32'h00000000,
                 32'h00000001, 32'h3F800000, 32'h7F800000, 32'h7F800001, 32'h7FC00000};
    for (int i = 0; i < 10; i++) begin
      exec(fpuPkg::OpMvWX, 12, 1, 0, classVal[i]);
      exec(fpuPkg::OpClass, 0, 12, 0, 0);
    end

    testName = "loadUse";
    exec(fpuPkg::OpLoad, 13, 2, 0, $random(seed));
    exec(fpuPkg::OpSgnjx, 14, 13, 13, 0);        // Reads the load destination at once
    assert (lastStalls == 1) else begin
      errors++;
      $display("Load-use stall lasted %0d cycles instead of one", lastStalls);
    end
    exec(fpuPkg::OpMvXW, 0, 14, 0, 0);

    testName = "illegal";
    illegal({7'b0000000, 5'd2, 5'd3, 3'b000, 5'd1, 7'b1010011});  // fadd.s f1
    idle(1);
    statusFs = 2'b00;                            // FP state off
    illegal({7'b0010000, 5'd2, 5'd3, 3'b000, 5'd1, 7'b1010011});
    idle(1);                                     // fsgnj leaves D while FP is still off
    statusFs = 2'b01;
    exec(fpuPkg::OpMvXW, 0, 1, 0, 0);            // f1 still holds its load value

    idle(6);
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // Run length guard
  always @(posedge clk) begin
    cycles++;
    if (cycles >= Limit) begin
      $display("Timeout after %0d cycles, the test did not finish", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

endmodule

/* vlog.f */
source/fpuPkg.sv
source/fpDecoder.sv
source/fpRegFile.sv
source/fpHazard.sv
source/fpUnpack.sv
source/fpSimpleOps.sv
source/fpu.sv
tests/fpuTb.sv
